// File: rtl/cam_track_pkg.sv
package cam_track_pkg;

   // frame geometry of the camera window
   localparam int FRAME_W = 320;
   localparam int FRAME_H = 180;

   // bus and pixel types
   typedef logic [7:0]  cam_byte_t;
   typedef logic [15:0] rgb565_t;
   typedef logic [8:0]  pix_x_t;
   typedef logic [7:0]  pix_y_t;
   typedef logic [7:0]  chroma_t;

   // pink band on cr, both bounds inclusive
   localparam chroma_t CR_LOWER = 8'hA0;
   localparam chroma_t CR_UPPER = 8'hF0;

   // cr weights, green and blue are subtracted
   localparam int CR_COEF_R = 112;
   localparam int CR_COEF_G = 94;
   localparam int CR_COEF_B = 18;
   localparam int CR_OFFSET = 128;
   localparam int CR_SHIFT  = 8;

   // widest product is 112 * 248
   localparam int CR_PROD_W = 15;
   // signed sum of three products plus headroom
   localparam int CR_SUM_W  = 17;

   // accumulators sized for a full frame of hits
   localparam int SUM_X_W = 24;
   localparam int SUM_Y_W = 23;
   localparam int CNT_W   = 16;

   // divider step counter, one step per dividend bit
   localparam int DIV_STEP_W = $clog2(SUM_X_W + 1);

endpackage

// File: rtl/pixel_reconstruct.sv
`timescale 1ns/1ps

module pixel_reconstruct (
   input  logic                     clk_camera,
   input  logic                     sys_rst_camera,
   input  cam_track_pkg::cam_byte_t cam_data_i,
   input  logic                     cam_pclk_i,
   input  logic                     cam_hsync_i,
   input  logic                     cam_vsync_i,
   output logic                     pix_valid_o,
   output cam_track_pkg::rgb565_t   pix_data_o,
   output cam_track_pkg::pix_x_t    pix_x_o,
   output cam_track_pkg::pix_y_t    pix_y_o
);
   import cam_track_pkg::*;

   // two flop synchronizers
   cam_byte_t data_s1;
   cam_byte_t data_s2;
   logic      pclk_s1;
   logic      pclk_s2;
   logic      hsync_s1;
   logic      hsync_s2;
   logic      vsync_s1;
   logic      vsync_s2;

   // edge stage, data kept aligned with the pclk rise
   logic      pclk_d;
   logic      pclk_rise;
   cam_byte_t data_e;
   logic      hsync_e;
   logic      vsync_e;

   // byte pairing and raster position
   logic      hsync_prev;
   logic      phase;
   cam_byte_t hi_byte;
   pix_x_t    col;
   pix_y_t    row;
   logic      take_byte;

   always_ff @(posedge clk_camera) begin
      data_s1  <= cam_data_i;
      data_s2  <= data_s1;
      pclk_s1  <= cam_pclk_i;
      pclk_s2  <= pclk_s1;
      hsync_s1 <= cam_hsync_i;
      hsync_s2 <= hsync_s1;
      vsync_s1 <= cam_vsync_i;
      vsync_s2 <= vsync_s1;
   end

   always_ff @(posedge clk_camera) begin
      pclk_d  <= pclk_s2;
      data_e  <= data_s2;
      hsync_e <= hsync_s2;
      vsync_e <= vsync_s2;
      if (sys_rst_camera) begin
         pclk_rise <= 1'b0;
      end else begin
         pclk_rise <= pclk_s2 & ~pclk_d;
      end
   end

   // bytes only count inside an active line
   assign take_byte = pclk_rise & hsync_e & ~vsync_e;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pix_valid_o <= 1'b0;
         phase       <= 1'b0;
         col         <= '0;
         row         <= '0;
         hsync_prev  <= 1'b0;
      end else begin
         hsync_prev  <= hsync_e;
         pix_valid_o <= 1'b0;
         // row steps on hsync fall, held at zero through vsync
         if (vsync_e) begin
            row <= '0;
         end else if (hsync_prev && !hsync_e) begin
            row <= row + 1'b1;
         end
         // blanking clears column and byte phase
         if (!hsync_e) begin
            phase <= 1'b0;
            col   <= '0;
         end else if (take_byte) begin
            if (!phase) begin
               phase <= 1'b1;
            end else begin
               phase       <= 1'b0;
               pix_valid_o <= 1'b1;
               col         <= col + 1'b1;
            end
         end
      end
   end

   // high byte first, low byte completes the pixel
   always_ff @(posedge clk_camera) begin
      if (take_byte && !phase) begin
         hi_byte <= data_e;
      end
      if (take_byte && phase) begin
         pix_data_o <= {hi_byte, data_e};
         pix_x_o    <= col;
         pix_y_o    <= row;
      end
   end

   // column never runs past the line width
   a_col_in_frame: assert property (
      @(posedge clk_camera) disable iff (sys_rst_camera)
      pix_valid_o |-> (pix_x_o < FRAME_W)
   ) else $error("pix_x_o out of frame: %h", pix_x_o);

endmodule

// File: rtl/chroma_mask.sv
`timescale 1ns/1ps

module chroma_mask (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   input  logic                   pix_valid_i,
   input  cam_track_pkg::rgb565_t pix_data_i,
   input  cam_track_pkg::pix_x_t  pix_x_i,
   input  cam_track_pkg::pix_y_t  pix_y_i,
   output logic                   mask_valid_o,
   output logic                   mask_o,
   output cam_track_pkg::pix_x_t  mask_x_o,
   output cam_track_pkg::pix_y_t  mask_y_o
);
   import cam_track_pkg::*;

   // stage 1, channels widened to 8 bits
   logic    valid_1;
   chroma_t red8;
   chroma_t green8;
   chroma_t blue8;
   pix_x_t  x_1;
   pix_y_t  y_1;

   // stage 2, weighted products
   logic                 valid_2;
   logic [CR_PROD_W-1:0] prod_r;
   logic [CR_PROD_W-1:0] prod_g;
   logic [CR_PROD_W-1:0] prod_b;
   pix_x_t               x_2;
   pix_y_t               y_2;

   // stage 3 combinational cr and band test
   logic signed [CR_SUM_W-1:0] cr_sum;
   logic signed [CR_SUM_W-1:0] cr_off;
   chroma_t                    cr;
   logic                       in_band;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         valid_1      <= 1'b0;
         valid_2      <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         valid_1      <= pix_valid_i;
         valid_2      <= valid_1;
         mask_valid_o <= valid_2;
      end
   end

   always_ff @(posedge clk_camera) begin
      // zero fill the low bits
      red8   <= {pix_data_i[15:11], 3'b000};
      green8 <= {pix_data_i[10:5], 2'b00};
      blue8  <= {pix_data_i[4:0], 3'b000};
      x_1    <= pix_x_i;
      y_1    <= pix_y_i;
      prod_r <= CR_PROD_W'(CR_COEF_R * red8);
      prod_g <= CR_PROD_W'(CR_COEF_G * green8);
      prod_b <= CR_PROD_W'(CR_COEF_B * blue8);
      x_2    <= x_1;
      y_2    <= y_1;
      mask_o   <= in_band;
      mask_x_o <= x_2;
      mask_y_o <= y_2;
   end

   always_comb begin
      cr_sum = $signed({2'b00, prod_r}) - $signed({2'b00, prod_g})
               - $signed({2'b00, prod_b});
      // arithmetic shift gives floor on negatives
      cr_off = (cr_sum >>> CR_SHIFT) + $signed(CR_SUM_W'(CR_OFFSET));
      if (cr_off < 0) begin
         cr = '0;
      end else if (cr_off > 255) begin
         cr = 8'hFF;
      end else begin
         cr = cr_off[7:0];
      end
      in_band = (cr >= CR_LOWER) && (cr <= CR_UPPER);
   end

endmodule

// File: rtl/com_divider.sv
`timescale 1ns/1ps

module com_divider (
   input  logic                                clk_camera,
   input  logic                                sys_rst_camera,
   input  logic                                start_i,
   input  logic [cam_track_pkg::SUM_X_W-1:0]   dividend_i,
   input  logic [cam_track_pkg::CNT_W-1:0]     divisor_i,
   output logic                                busy_o,
   output logic                                done_o,
   output cam_track_pkg::pix_x_t               quotient_o
);
   import cam_track_pkg::*;

   // dividend shifts out the top, quotient bits shift in the bottom
   logic [SUM_X_W-1:0]    work;
   logic [CNT_W-1:0]      rem;
   logic [CNT_W-1:0]      dvs;
   logic [DIV_STEP_W-1:0] steps;
   logic [CNT_W:0]        rem_shift;
   logic [CNT_W:0]        trial;
   logic                  q_bit;

   always_comb begin
      rem_shift = {rem, work[SUM_X_W-1]};
      trial     = rem_shift - {1'b0, dvs};
      // no borrow means the divisor fits
      q_bit     = ~trial[CNT_W];
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         busy_o <= 1'b0;
         done_o <= 1'b0;
         steps  <= '0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            busy_o <= 1'b1;
            steps  <= DIV_STEP_W'(SUM_X_W);
         end else if (busy_o) begin
            steps <= steps - 1'b1;
            if (steps == 1) begin
               busy_o <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_camera) begin
      if (start_i) begin
         work <= dividend_i;
         rem  <= '0;
         dvs  <= divisor_i;
      end else if (busy_o) begin
         work <= {work[SUM_X_W-2:0], q_bit};
         rem  <= q_bit ? trial[CNT_W-1:0] : rem_shift[CNT_W-1:0];
         // last step, quotient held until the next start
         if (steps == 1) begin
            quotient_o <= {work[$bits(pix_x_t)-2:0], q_bit};
         end
      end
   end

   a_no_restart: assert property (
      @(posedge clk_camera) disable iff (sys_rst_camera)
      start_i |-> !busy_o
   ) else $error("divider restarted while busy");

endmodule

// File: rtl/center_of_mass.sv
`timescale 1ns/1ps

module center_of_mass (
   input  logic                  clk_camera,
   input  logic                  sys_rst_camera,
   input  logic                  mask_valid_i,
   input  logic                  mask_i,
   input  cam_track_pkg::pix_x_t mask_x_i,
   input  cam_track_pkg::pix_y_t mask_y_i,
   output logic                  com_valid_o,
   output cam_track_pkg::pix_x_t com_x_o,
   output cam_track_pkg::pix_y_t com_y_o
);
   import cam_track_pkg::*;

   typedef enum logic [1:0] {
      COM_IDLE,
      COM_START,
      COM_WAIT
   } com_state_t;

   com_state_t       state;
   logic [SUM_X_W-1:0] sum_x;
   logic [SUM_Y_W-1:0] sum_y;
   logic [CNT_W-1:0]   cnt;
   logic [SUM_X_W-1:0] nxt_sum_x;
   logic [SUM_Y_W-1:0] nxt_sum_y;
   logic [CNT_W-1:0]   nxt_cnt;
   logic [SUM_X_W-1:0] tot_x;
   logic [SUM_Y_W-1:0] tot_y;
   logic [CNT_W-1:0]   tot_cnt;
   logic               hit;
   logic               tabulate;
   logic               div_start;
   logic               busy_x;
   logic               busy_y;
   logic               done_x;
   logic               done_y;
   logic               got_x;
   logic               got_y;
   pix_x_t             quo_x;
   pix_x_t             quo_y;

   assign hit      = mask_valid_i & mask_i;
   // last pixel of the frame closes the tally
   assign tabulate = mask_valid_i && (mask_x_i == pix_x_t'(FRAME_W - 1))
                     && (mask_y_i == pix_y_t'(FRAME_H - 1));
   assign div_start = (state == COM_START) && !busy_x && !busy_y;

   // running totals including the pixel on the input
   always_comb begin
      nxt_sum_x = sum_x + (hit ? SUM_X_W'(mask_x_i) : '0);
      nxt_sum_y = sum_y + (hit ? SUM_Y_W'(mask_y_i) : '0);
      nxt_cnt   = cnt + (hit ? CNT_W'(1) : '0);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera || tabulate) begin
         sum_x <= '0;
         sum_y <= '0;
         cnt   <= '0;
      end else begin
         sum_x <= nxt_sum_x;
         sum_y <= nxt_sum_y;
         cnt   <= nxt_cnt;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (tabulate) begin
         tot_x   <= nxt_sum_x;
         tot_y   <= nxt_sum_y;
         tot_cnt <= nxt_cnt;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state       <= COM_IDLE;
         got_x       <= 1'b0;
         got_y       <= 1'b0;
         com_valid_o <= 1'b0;
         com_x_o     <= '0;
         com_y_o     <= '0;
      end else begin
         com_valid_o <= 1'b0;
         case (state)
            // empty frame leaves the old result in place
            COM_IDLE: begin
               if (tabulate && (nxt_cnt != '0)) begin
                  state <= COM_START;
               end
            end
            COM_START: begin
               if (div_start) begin
                  state <= COM_WAIT;
                  got_x <= 1'b0;
                  got_y <= 1'b0;
               end
            end
            COM_WAIT: begin
               if (done_x) begin
                  got_x <= 1'b1;
               end
               if (done_y) begin
                  got_y <= 1'b1;
               end
               // both quotients in hand
               if ((got_x || done_x) && (got_y || done_y)) begin
                  com_valid_o <= 1'b1;
                  com_x_o     <= quo_x;
                  com_y_o     <= pix_y_t'(quo_y);
                  state       <= COM_IDLE;
               end
            end
            default: state <= COM_IDLE;
         endcase
      end
   end

   com_divider div_x (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (tot_x),
      .divisor_i      (tot_cnt),
      .busy_o         (busy_x),
      .done_o         (done_x),
      .quotient_o     (quo_x)
   );

   // y sum zero extended to the shared divider width
   com_divider div_y (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .start_i        (div_start),
      .dividend_i     (SUM_X_W'(tot_y)),
      .divisor_i      (tot_cnt),
      .busy_o         (busy_y),
      .done_o         (done_y),
      .quotient_o     (quo_y)
   );

endmodule

// File: rtl/blob_tracker_top.sv
`timescale 1ns/1ps

module blob_tracker_top (
   input  logic                     clk_camera,
   input  logic                     sys_rst_camera,
   input  cam_track_pkg::cam_byte_t cam_data_i,
   input  logic                     cam_pclk_i,
   input  logic                     cam_hsync_i,
   input  logic                     cam_vsync_i,
   output logic                     mask_valid_o,
   output logic                     mask_o,
   output cam_track_pkg::pix_x_t    mask_x_o,
   output cam_track_pkg::pix_y_t    mask_y_o,
   output logic                     com_valid_o,
   output cam_track_pkg::pix_x_t    com_x_o,
   output cam_track_pkg::pix_y_t    com_y_o
);
   import cam_track_pkg::*;

   // reconstructed pixel stream
   logic    pix_valid;
   rgb565_t pix_data;
   pix_x_t  pix_x;
   pix_y_t  pix_y;

   pixel_reconstruct pix_rec0 (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pix_valid_o    (pix_valid),
      .pix_data_o     (pix_data),
      .pix_x_o        (pix_x),
      .pix_y_o        (pix_y)
   );

   chroma_mask chroma0 (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pix_valid_i    (pix_valid),
      .pix_data_i     (pix_data),
      .pix_x_i        (pix_x),
      .pix_y_i        (pix_y),
      .mask_valid_o   (mask_valid_o),
      .mask_o         (mask_o),
      .mask_x_o       (mask_x_o),
      .mask_y_o       (mask_y_o)
   );

   // mask stream feeds both the outputs and the tally
   center_of_mass com0 (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_valid_i   (mask_valid_o),
      .mask_i         (mask_o),
      .mask_x_i       (mask_x_o),
      .mask_y_i       (mask_y_o),
      .com_valid_o    (com_valid_o),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o)
   );

endmodule

// File: verif/blob_tracker_tb.sv
`timescale 1ns/1ps

module blob_tracker_tb;
   import cam_track_pkg::*;

   localparam int NUM_FRAMES = 5;
   localparam int FRAME_PIX  = FRAME_W * FRAME_H;
   localparam int GAP_MAX    = 15;
   localparam int COM_WINDOW = 30;
   localparam int CR_DIV     = 1 << CR_SHIFT;
   // 8 clocks per pixel plus blanking, worst case line gaps
   localparam int FRAME_CYC   = FRAME_PIX * 8 + (FRAME_H + 5) * (GAP_MAX + 2) + 100;
   localparam int TIMEOUT_CYC = NUM_FRAMES * FRAME_CYC * 3 / 2;

   logic      clk_camera = 1'b0;
   logic      sys_rst_camera;
   cam_byte_t cam_data_i;
   logic      cam_pclk_i;
   logic      cam_hsync_i;
   logic      cam_vsync_i;
   logic      mask_valid_o;
   logic      mask_o;
   pix_x_t    mask_x_o;
   pix_y_t    mask_y_o;
   logic      com_valid_o;
   pix_x_t    com_x_o;
   pix_y_t    com_y_o;

   // row fields x0 x1 y0 y1 fg bg
   logic [65:0] frame_tab [NUM_FRAMES];

   int err_mask = 0;
   int err_com  = 0;
   int err_misc = 0;
   int cyc = 0;
   int mask_total = 0;
   // model tally of the frame in flight
   int sum_x = 0;
   int sum_y = 0;
   int cnt   = 0;
   int exp_x = 0;
   int exp_y = 0;
   int prev_x = 0;
   int prev_y = 0;
   int since_end = 0;
   logic pending   = 1'b0;
   logic exp_pulse = 1'b0;
   logic got_com   = 1'b0;

   blob_tracker_top dut0 (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .mask_valid_o   (mask_valid_o),
      .mask_o         (mask_o),
      .mask_x_o       (mask_x_o),
      .mask_y_o       (mask_y_o),
      .com_valid_o    (com_valid_o),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o)
   );

   always #20 clk_camera = ~clk_camera;

   always @(posedge clk_camera) begin
      cyc = cyc + 1;
      if (cyc >= TIMEOUT_CYC) begin
         err_misc++;
         $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("errors: mask %0d com %0d other %0d", err_mask, err_com, err_misc);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // rectangle foreground, background elsewhere
   function automatic rgb565_t pixel_at(input int f, input int x, input int y);
      logic [65:0] row;
      row = frame_tab[f];
      if (x >= int'(row[65:57]) && x <= int'(row[56:48]) &&
          y >= int'(row[47:40]) && y <= int'(row[39:32])) begin
         return row[31:16];
      end
      return row[15:0];
   endfunction

   function automatic int cr_model(input rgb565_t p);
      int red8;
      int green8;
      int blue8;
      int num;
      int q;
      int cr;
      red8   = int'(p[15:11]) * 8;
      green8 = int'(p[10:5]) * 4;
      blue8  = int'(p[4:0]) * 8;
      num    = CR_COEF_R * red8 - CR_COEF_G * green8 - CR_COEF_B * blue8;
      // round toward minus infinity
      if (num >= 0) begin
         q = num / CR_DIV;
      end else begin
         q = -((-num + CR_DIV - 1) / CR_DIV);
      end
      cr = CR_OFFSET + q;
      if (cr < 0) cr = 0;
      if (cr > 255) cr = 255;
      return cr;
   endfunction

   function automatic logic band_hit(input int cr);
      return (cr >= int'(CR_LOWER)) && (cr <= int'(CR_UPPER));
   endfunction

   // one bus byte, one full pclk period
   task automatic send_byte(input cam_byte_t b);
      cam_data_i = b;
      cam_pclk_i = 1'b0;
      repeat (2) @(negedge clk_camera);
      cam_pclk_i = 1'b1;
      repeat (2) @(negedge clk_camera);
   endtask

   task automatic send_frame(input int f);
      int      gap;
      int      x;
      int      y;
      rgb565_t px;
      gap = 8 + $urandom % 8;
      cam_vsync_i = 1'b1;
      cam_hsync_i = 1'b0;
      repeat (4 * gap) @(negedge clk_camera);
      cam_vsync_i = 1'b0;
      for (y = 0; y < FRAME_H; y++) begin
         repeat (gap) @(negedge clk_camera);
         cam_hsync_i = 1'b1;
         repeat (2) @(negedge clk_camera);
         for (x = 0; x < FRAME_W; x++) begin
            px = pixel_at(f, x, y);
            send_byte(px[15:8]);
            send_byte(px[7:0]);
         end
         cam_pclk_i  = 1'b0;
         cam_hsync_i = 1'b0;
      end
      repeat (gap) @(negedge clk_camera);
   endtask

   task automatic check_idle();
      if (mask_valid_o !== 1'b0) begin
         err_misc++;
         $display("FAIL mask_valid_o got %h exp %h", mask_valid_o, 1'b0);
      end
      if (com_valid_o !== 1'b0) begin
         err_com++;
         $display("FAIL com_valid_o got %h exp %h", com_valid_o, 1'b0);
      end
      if (com_x_o !== '0 || com_y_o !== '0) begin
         err_com++;
         $display("FAIL com_x_o/com_y_o got %h/%h exp 0/0", com_x_o, com_y_o);
      end
   endtask

   task automatic check_mask_beat();
      int   f;
      int   idx;
      int   ex;
      int   ey;
      logic em;
      f   = mask_total / FRAME_PIX;
      idx = mask_total % FRAME_PIX;
      ex  = idx % FRAME_W;
      ey  = idx / FRAME_W;
      mask_total++;
      if (f >= NUM_FRAMES) begin
         err_misc++;
         $display("mask_valid_o pulse after the last frame was complete");
      end else begin
         em = band_hit(cr_model(pixel_at(f, ex, ey)));
         if (mask_x_o !== pix_x_t'(ex) || mask_y_o !== pix_y_t'(ey)) begin
            err_mask++;
            $display("FAIL mask_x_o/mask_y_o got %h/%h exp %h/%h",
                     mask_x_o, mask_y_o, pix_x_t'(ex), pix_y_t'(ey));
         end
         if (mask_o !== em) begin
            err_mask++;
            $display("FAIL mask_o at %h,%h got %h exp %h", ex, ey, mask_o, em);
         end
         if (em) begin
            sum_x += ex;
            sum_y += ey;
            cnt++;
         end
         // last pixel opens the result window
         if (idx == FRAME_PIX - 1) begin
            pending   = 1'b1;
            got_com   = 1'b0;
            since_end = 0;
            exp_pulse = (cnt != 0);
            if (cnt != 0) begin
               exp_x = sum_x / cnt;
               exp_y = sum_y / cnt;
            end
            sum_x = 0;
            sum_y = 0;
            cnt   = 0;
         end
      end
   endtask

   task automatic track_com();
      if (com_valid_o === 1'b1) begin
         if (!pending || got_com || !exp_pulse) begin
            err_com++;
            $display("com_valid_o pulsed where no result was due");
         end else begin
            got_com = 1'b1;
            if (com_x_o !== pix_x_t'(exp_x) || com_y_o !== pix_y_t'(exp_y)) begin
               err_com++;
               $display("FAIL com_x_o/com_y_o got %h/%h exp %h/%h",
                        com_x_o, com_y_o, pix_x_t'(exp_x), pix_y_t'(exp_y));
            end
            prev_x = exp_x;
            prev_y = exp_y;
         end
      end
      if (pending) begin
         since_end++;
         if (since_end >= COM_WINDOW) begin
            pending = 1'b0;
            if (exp_pulse && !got_com) begin
               err_com++;
               $display("no com_valid_o pulse within %0d cycles of frame end", COM_WINDOW);
            end
            // empty frame keeps the old centre
            if (com_x_o !== pix_x_t'(prev_x) || com_y_o !== pix_y_t'(prev_y)) begin
               err_com++;
               $display("FAIL com_x_o/com_y_o got %h/%h exp %h/%h",
                        com_x_o, com_y_o, pix_x_t'(prev_x), pix_y_t'(prev_y));
            end
         end
      end
   endtask

   always @(negedge clk_camera) begin
      if (mask_valid_o === 1'b1) begin
         check_mask_beat();
      end
      track_com();
   end

   initial begin
      int f;
      int wait_cyc;
      void'($urandom(36389));
      sys_rst_camera = 1'b1;
      cam_data_i     = '0;
      cam_pclk_i     = 1'b0;
      cam_hsync_i    = 1'b0;
      cam_vsync_i    = 1'b1;
      // pink on black
      frame_tab[0] = {9'd40, 9'd99, 8'd20, 8'd59, 16'hF810, 16'h0000};
      // cr 160 on cr 159, both sides of the lower edge
      frame_tab[1] = {9'd100, 9'd199, 8'd50, 8'd149, 16'h5040, 16'h5041};
      // full red, cr 236 near the top, on white with negative sum
      frame_tab[2] = {9'd200, 9'd260, 8'd100, 8'd170, 16'hF800, 16'hFFFF};
      // all green, nothing masked
      frame_tab[3] = {9'd0, 9'd0, 8'd0, 8'd0, 16'h07E0, 16'h07E0};
      // single pixel in the last corner
      frame_tab[4] = {9'd319, 9'd319, 8'd179, 8'd179, 16'hF810, 16'h0000};
      repeat (3) begin
         @(negedge clk_camera);
         check_idle();
      end
      sys_rst_camera = 1'b0;
      repeat (4) begin
         @(negedge clk_camera);
         check_idle();
      end
      for (f = 0; f < NUM_FRAMES; f++) begin
         send_frame(f);
      end
      // drain mask stream and the last result window
      for (wait_cyc = 0; wait_cyc < 200; wait_cyc++) begin
         if (mask_total >= NUM_FRAMES * FRAME_PIX && !pending) break;
         @(negedge clk_camera);
      end
      if (mask_total != NUM_FRAMES * FRAME_PIX || pending) begin
         err_misc++;
         $display("mask stream gave %0d beats where %0d were sent",
                  mask_total, NUM_FRAMES * FRAME_PIX);
      end
      $display("errors: mask %0d com %0d other %0d", err_mask, err_com, err_misc);
      if (err_mask + err_com + err_misc == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: tb.f
rtl/cam_track_pkg.sv
rtl/pixel_reconstruct.sv
rtl/chroma_mask.sv
rtl/com_divider.sv
rtl/center_of_mass.sv
rtl/blob_tracker_top.sv
verif/blob_tracker_tb.sv
